//--- Makefile
VERILATOR ?= verilator
TB_TOP    ?= devices_tb
RTL_TOP   ?= devices
FILELIST  ?= devices.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing
PASS_TEXT ?= All checks passed

SOURCES := $(shell cat $(FILELIST))
RTL_SRC := $(filter verilog/%,$(SOURCES))
SIM     := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: build
	@out="$$(./$(SIM))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_TEXT)"

lint:
	$(VERILATOR) --lint-only --top-module $(RTL_TOP) $(RTL_SRC)

clean:
	rm -rf $(BUILD_DIR)

//--- devices.f
verilog/msx_io_pkg.sv
verilog/io_port_decoder.sv
verilog/dev_psg.sv
verilog/dev_ppi.sv
verilog/dev_mapper_regs.sv
verilog/sound_mixer.sv
verilog/devices.sv
dv/clock_gen.sv
dv/devices_tb.sv

//--- dv/clock_gen.sv
`timescale 1ns/1ps

module clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 2
) (
    output logic clk,
    output logic arst_n
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

    // Reset is released on a falling edge, clear of the register updates
    initial begin
        arst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
    end

endmodule

//--- dv/devices_golden.txt
# op args in hex, except S in decimal: W port data | R port data oe | K row byte
# J sel(0 joy_a 1 joy_b 2 tape) value | E mask | M page seg | C slot | S sound | T name
T mapper_regs
R FC F3 1
R FD F2 1
R FE F1 1
R FF F0 1
M 0 03
M 3 00
W FD 27
R FD F7 1
W FE 0A
R FE FA 1
M 1 07
M 2 0A
T psg_regs
W A0 00
W A1 5A
R A2 5A 1
W A0 0D
W A1 C3
R A2 C3 1
J 0 15
J 1 2A
J 2 1
W A0 0E
R A2 D5 1
W A0 0F
W A1 40
W A0 0E
R A2 EA 1
J 2 0
R A2 6A 1
T ppi
W A8 A5
R A8 A5 1
C A5
K 3 5C
W AA 03
R A9 5C 1
R AA 03 1
W AA 0C
R A9 FF 1
W A8 00
C 00
T sound
S 0
W A0 07
W A1 3F
W A0 08
W A1 03
W A0 09
W A1 05
W A0 0A
W A1 07
S 7680
W A0 08
W A1 0F
W A0 09
W A1 0F
W A0 0A
W A1 0F
S 23040
W AA 80
S 32767
W AA 00
S 23040
T decode
R 50 FF 0
E 6
R A2 FF 0
W A0 08
W A1 00
S 23040
E 3
R FD FF 0
W FD 01
E 7
R FD F7 1
R A2 0F 1
E 5
R A8 FF 0
E 7
R A8 00 1

//--- dv/devices_tb.sv
`timescale 1ns/1ps

module devices_tb;

    localparam string GOLDEN_FILE     = "dv/devices_golden.txt";
    localparam int    CYCLES_PER_LINE = 20;

    logic               clk;
    logic               arst_n;
    logic [7:0]         io_addr;
    logic [7:0]         io_wdata;
    logic               io_wr;
    logic               io_rd;
    logic [2:0]         dev_enable;
    logic [5:0]         joy_a;
    logic [5:0]         joy_b;
    logic               tape_in;
    logic [87:0]        key_rows;
    logic [1:0]         mem_addr;
    logic [7:0]         io_rdata;
    logic               io_rdata_oe;
    logic [7:0]         slot_config;
    logic [7:0]         mapper_segment;
    logic signed [15:0] sound;

    int              golden_lines;
    bit              lines_counted;
    int              checks;
    int              errors;
    int              tests;
    int              test_errors;
    logic [8*32-1:0] test_name;
    bit              in_test;

    clock_gen u_clk (
        .clk    (clk),
        .arst_n (arst_n)
    );

    devices dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .io_addr        (io_addr),
        .io_wdata       (io_wdata),
        .io_wr          (io_wr),
        .io_rd          (io_rd),
        .dev_enable     (dev_enable),
        .joy_a          (joy_a),
        .joy_b          (joy_b),
        .tape_in        (tape_in),
        .key_rows       (key_rows),
        .mem_addr       (mem_addr),
        .io_rdata       (io_rdata),
        .io_rdata_oe    (io_rdata_oe),
        .slot_config    (slot_config),
        .mapper_segment (mapper_segment),
        .sound          (sound)
    );

    task automatic check_value(input string name, input int expv, input int actv);
        checks++;
        if (actv != expv) begin
            $display("ERR t=%0t %s expected 0x%0h (%0d) got 0x%0h (%0d)",
                     $time, name, expv, expv, actv, actv);
            errors++;
            test_errors++;
        end
    endtask

    task automatic finish_test();
        if (in_test) begin
            if (test_errors == 0) begin
                $display("test %0s: PASS", test_name);
            end else begin
                $display("test %0s: FAIL with %0d errors", test_name, test_errors);
            end
        end
        in_test = 1'b0;
    endtask

    // Starts on a falling edge and holds io_wr over one rising edge
    task automatic bus_write(input logic [7:0] port, input logic [7:0] data);
        io_addr  = port;
        io_wdata = data;
        io_wr    = 1'b1;
        @(negedge clk);
        io_wr = 1'b0;
        @(negedge clk);
    endtask

    // Read data is sampled one falling edge after the address
    task automatic bus_read(input logic [7:0] port, input logic [7:0] expv, input logic oe);
        io_addr = port;
        io_rd   = 1'b1;
        @(negedge clk);
        check_value($sformatf("io_rdata@%02h", port), int'(expv), int'(io_rdata));
        check_value($sformatf("io_rdata_oe@%02h", port), int'(oe), int'(io_rdata_oe));
        io_rd = 1'b0;
    endtask

    task automatic run_op(input string line, input logic [7:0] op);
        logic [7:0]      tag;
        logic [31:0]     a;
        logic [31:0]     b;
        logic [31:0]     c;
        int              sval;
        int              row;
        logic [8*32-1:0] name;
        a = '0;
        b = '0;
        c = '0;
        case (op)
            "T": begin
                name = '0;
                void'($sscanf(line, "%c %s", tag, name));
                finish_test();
                test_name   = name;
                test_errors = 0;
                in_test     = 1'b1;
                tests++;
            end
            "S": begin
                void'($sscanf(line, "%c %d", tag, sval));
                // Room for the register update and the mixer register
                repeat (4) @(negedge clk);
                check_value("sound", sval, int'(sound));
            end
            default: begin
                void'($sscanf(line, "%c %h %h %h", tag, a, b, c));
                case (op)
                    "W": bus_write(a[7:0], b[7:0]);
                    "R": bus_read(a[7:0], b[7:0], c[0]);
                    "K": begin
                        row = int'(a[3:0]);
                        key_rows[row*8 +: 8] = b[7:0];
                    end
                    "J": begin
                        case (a[1:0])
                            2'd0:    joy_a = b[5:0];
                            2'd1:    joy_b = b[5:0];
                            default: tape_in = b[0];
                        endcase
                    end
                    "E": dev_enable = a[2:0];
                    "M": begin
                        mem_addr = a[1:0];
                        @(negedge clk);
                        check_value("mapper_segment", int'(b[7:0]), int'(mapper_segment));
                    end
                    "C": check_value("slot_config", int'(a[7:0]), int'(slot_config));
                    default: begin
                        $display("Unknown operation '%c' in the golden file", op);
                        errors++;
                    end
                endcase
            end
        endcase
    endtask

    initial begin
        int         fd;
        int         n;
        string      line;
        logic [7:0] op;
        io_addr    = '0;
        io_wdata   = '0;
        io_wr      = 1'b0;
        io_rd      = 1'b0;
        dev_enable = 3'b111;
        joy_a      = '0;
        joy_b      = '0;
        tape_in    = 1'b0;
        mem_addr   = '0;
        void'($urandom(1));
        // Rows the golden file never sets keep random contents
        for (int i = 0; i < 11; i++) begin
            key_rows[i*8 +: 8] = 8'($urandom);
        end

        fd = $fopen(GOLDEN_FILE, "r");
        if (fd == 0) begin
            $display("Cannot open the golden file %s", GOLDEN_FILE);
            errors++;
        end else begin
            while ($fgets(line, fd) != 0) begin
                golden_lines++;
            end
            $fclose(fd);
            fd = $fopen(GOLDEN_FILE, "r");
            lines_counted = 1'b1;
        end

        wait (arst_n === 1'b1);
        @(negedge clk);
        if (fd != 0) begin
            while ($fgets(line, fd) != 0) begin
                n = $sscanf(line, "%c", op);
                if (n < 1 || op == "#" || op == "\n" || op == "\r" || op == " ") begin
                    continue;
                end
                run_op(line, op);
            end
            $fclose(fd);
        end
        finish_test();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // Budget scales with the length of the golden file
    initial begin
        wait (lines_counted);
        repeat (golden_lines * CYCLES_PER_LINE) @(posedge clk);
        $display("Timeout: golden operations still running after %0d cycles",
                 golden_lines * CYCLES_PER_LINE);
        $display("Checks failed");
        $finish;
    end

endmodule

//--- verilog/dev_mapper_regs.sv
`timescale 1ns/1ps

module dev_mapper_regs
    import msx_io_pkg::*;
#(
    parameter int MAPPER_SEGMENTS = 16
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       sel,
    input  logic [1:0] reg_idx,
    input  logic       io_wr,
    input  logic       io_rd,
    input  logic [7:0] io_wdata,
    input  logic [1:0] mem_addr,
    output logic [7:0] rdata,
    output logic [7:0] mapper_segment
);

    localparam int SEG_W = (MAPPER_SEGMENTS > 1) ? $clog2(MAPPER_SEGMENTS) : 1;

    // Bits above the segment number read back as ones
    localparam logic [7:0] UNUSED_MASK = ~8'((1 << SEG_W) - 1);

    logic [SEG_W-1:0] page [4];

    // Pages come out of reset mapped to segments 3, 2, 1, 0
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < 4; i++) begin
                page[i] <= SEG_W'(3 - i);
            end
        end else if (sel && io_wr) begin
            page[reg_idx] <= io_wdata[SEG_W-1:0];
        end
    end

    assign rdata = (sel && io_rd) ? (8'(page[reg_idx]) | UNUSED_MASK) : IO_IDLE;

    // Segment of the 16 KB page the CPU is addressing
    assign mapper_segment = 8'(page[mem_addr]);

endmodule

//--- verilog/dev_ppi.sv
`timescale 1ns/1ps

module dev_ppi
    import msx_io_pkg::*;
(
    input  logic        clk,
    input  logic        arst_n,
    input  logic        sel,
    input  logic [1:0]  reg_idx,
    input  logic        io_wr,
    input  logic        io_rd,
    input  logic [7:0]  io_wdata,
    input  logic [87:0] key_rows,
    output logic [7:0]  rdata,
    output logic [7:0]  slot_config,
    output logic        keybeep
);

    logic [7:0] slot_reg;
    logic [7:0] port_c;
    logic [3:0] key_row;
    logic [7:0] key_byte;

    // Port A holds the primary slot, port C the row select and beep
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            slot_reg <= '0;
            port_c   <= '0;
        end else if (sel && io_wr) begin
            case (reg_idx)
                2'd0: slot_reg <= io_wdata;
                2'd2: port_c   <= io_wdata;
                2'd3: begin
                    // Bit set/reset on port C when bit 7 is clear
                    if (!io_wdata[7]) begin
                        port_c[io_wdata[3:1]] <= io_wdata[0];
                    end
                end
                default: ;
            endcase
        end
    end

    assign key_row = port_c[3:0];

    // Eleven rows exist, higher rows read as no key pressed
    assign key_byte = (key_row < 4'd11) ? key_rows[key_row * 8 +: 8] : IO_IDLE;

    always_comb begin
        rdata = IO_IDLE;
        if (sel && io_rd) begin
            case (reg_idx)
                2'd0:    rdata = slot_reg;
                2'd1:    rdata = key_byte;
                2'd2:    rdata = port_c;
                default: rdata = IO_IDLE;
            endcase
        end
    end

    assign slot_config = slot_reg;
    assign keybeep     = port_c[7];

endmodule

//--- verilog/dev_psg.sv
`timescale 1ns/1ps

module dev_psg
    import msx_io_pkg::*;
#(
    parameter int TONE_PRESCALE = 16
) (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       sel,
    input  logic [1:0] reg_idx,
    input  logic       io_wr,
    input  logic       io_rd,
    input  logic [7:0] io_wdata,
    input  logic [5:0] joy_a,
    input  logic [5:0] joy_b,
    input  logic       tape_in,
    output logic [7:0] rdata,
    output logic [3:0] level_a,
    output logic [3:0] level_b,
    output logic [3:0] level_c
);

    localparam int PRE_W = (TONE_PRESCALE > 1) ? $clog2(TONE_PRESCALE) : 1;

    logic [7:0]       regs [16];
    logic [3:0]       reg_addr;
    logic [PRE_W-1:0] pre_cnt;
    logic             tone_tick;
    logic [11:0]      tone_cnt [3];
    logic [2:0]       tone_wave;
    logic [3:0]       level [3];
    logic [7:0]       joy_byte;
    logic [7:0]       read_byte;

    // Port 0 latches the register number, port 1 writes that register
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            reg_addr <= '0;
            for (int i = 0; i < 16; i++) begin
                regs[i] <= '0;
            end
        end else if (sel && io_wr) begin
            if (reg_idx == 2'd0) begin
                reg_addr <= io_wdata[3:0];
            end else if (reg_idx == 2'd1) begin
                regs[reg_addr] <= io_wdata;
            end
        end
    end

    // Shared prescaler, one tick every TONE_PRESCALE clocks
    assign tone_tick = (pre_cnt == PRE_W'(TONE_PRESCALE - 1));

    // Tone counters reload from the 12-bit period and flip the wave at zero
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pre_cnt   <= '0;
            tone_wave <= '0;
            for (int ch = 0; ch < 3; ch++) begin
                tone_cnt[ch] <= '0;
            end
        end else begin
            pre_cnt <= tone_tick ? '0 : pre_cnt + 1'b1;
            if (tone_tick) begin
                for (int ch = 0; ch < 3; ch++) begin
                    if (tone_cnt[ch] == 12'd0) begin
                        tone_cnt[ch]  <= {regs[2 * ch + 1][3:0], regs[2 * ch]};
                        tone_wave[ch] <= ~tone_wave[ch];
                    end else begin
                        tone_cnt[ch] <= tone_cnt[ch] - 12'd1;
                    end
                end
            end
        end
    end

    // A disabled tone holds the output high, so the volume passes straight through
    always_comb begin
        for (int ch = 0; ch < 3; ch++) begin
            level[ch] = (regs[7][ch] || tone_wave[ch]) ? regs[8 + ch][3:0] : 4'd0;
        end
    end

    assign level_a = level[0];
    assign level_b = level[1];
    assign level_c = level[2];

    // R14 is the input port: tape in bit 7, bit 6 always high
    // R15 bit 6 picks the joystick
    assign joy_byte  = {tape_in, 1'b1, regs[15][6] ? joy_b : joy_a};
    assign read_byte = (reg_addr == 4'd14) ? joy_byte : regs[reg_addr];

    // Only port 2 returns data
    assign rdata = (sel && io_rd && reg_idx == 2'd2) ? read_byte : IO_IDLE;

endmodule

//--- verilog/devices.sv
`timescale 1ns/1ps

module devices
    import msx_io_pkg::*;
#(
    parameter int MAPPER_SEGMENTS = 16,
    parameter int TONE_PRESCALE   = 16
) (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [7:0]                 io_addr,
    input  logic [7:0]                 io_wdata,
    input  logic                       io_wr,
    input  logic                       io_rd,
    input  logic [2:0]                 dev_enable,
    input  logic [5:0]                 joy_a,
    input  logic [5:0]                 joy_b,
    input  logic                       tape_in,
    input  logic [87:0]                key_rows,
    input  logic [1:0]                 mem_addr,
    output logic [7:0]                 io_rdata,
    output logic                       io_rdata_oe,
    output logic [7:0]                 slot_config,
    output logic [7:0]                 mapper_segment,
    output logic signed [SAMPLE_W-1:0] sound
);

    logic       psg_sel;
    logic       ppi_sel;
    logic       mapper_sel;
    logic [1:0] reg_idx;
    logic [7:0] psg_rdata;
    logic [7:0] ppi_rdata;
    logic [7:0] mapper_rdata;
    logic [3:0] level_a;
    logic [3:0] level_b;
    logic [3:0] level_c;
    logic       keybeep;

    io_port_decoder u_decoder (
        .io_addr     (io_addr),
        .io_rd       (io_rd),
        .dev_enable  (dev_enable),
        .psg_sel     (psg_sel),
        .ppi_sel     (ppi_sel),
        .mapper_sel  (mapper_sel),
        .reg_idx     (reg_idx),
        .io_rdata_oe (io_rdata_oe)
    );

    dev_psg #(
        .TONE_PRESCALE (TONE_PRESCALE)
    ) u_psg (
        .clk      (clk),
        .arst_n   (arst_n),
        .sel      (psg_sel),
        .reg_idx  (reg_idx),
        .io_wr    (io_wr),
        .io_rd    (io_rd),
        .io_wdata (io_wdata),
        .joy_a    (joy_a),
        .joy_b    (joy_b),
        .tape_in  (tape_in),
        .rdata    (psg_rdata),
        .level_a  (level_a),
        .level_b  (level_b),
        .level_c  (level_c)
    );

    dev_ppi u_ppi (
        .clk         (clk),
        .arst_n      (arst_n),
        .sel         (ppi_sel),
        .reg_idx     (reg_idx),
        .io_wr       (io_wr),
        .io_rd       (io_rd),
        .io_wdata    (io_wdata),
        .key_rows    (key_rows),
        .rdata       (ppi_rdata),
        .slot_config (slot_config),
        .keybeep     (keybeep)
    );

    dev_mapper_regs #(
        .MAPPER_SEGMENTS (MAPPER_SEGMENTS)
    ) u_mapper (
        .clk            (clk),
        .arst_n         (arst_n),
        .sel            (mapper_sel),
        .reg_idx        (reg_idx),
        .io_wr          (io_wr),
        .io_rd          (io_rd),
        .io_wdata       (io_wdata),
        .mem_addr       (mem_addr),
        .rdata          (mapper_rdata),
        .mapper_segment (mapper_segment)
    );

    sound_mixer u_mixer (
        .clk     (clk),
        .arst_n  (arst_n),
        .level_a (level_a),
        .level_b (level_b),
        .level_c (level_c),
        .keybeep (keybeep),
        .sound   (sound)
    );

    // Idle devices drive FF, so the AND leaves only the addressed byte
    assign io_rdata = psg_rdata & ppi_rdata & mapper_rdata;

endmodule

//--- verilog/io_port_decoder.sv
`timescale 1ns/1ps

module io_port_decoder
    import msx_io_pkg::*;
(
    input  logic [7:0] io_addr,
    input  logic       io_rd,
    input  logic [2:0] dev_enable,
    output logic       psg_sel,
    output logic       ppi_sel,
    output logic       mapper_sel,
    output logic [1:0] reg_idx,
    output logic       io_rdata_oe
);

    // Enable bits: 0 = PSG, 1 = PPI, 2 = mapper
    localparam int EN_PSG    = 0;
    localparam int EN_PPI    = 1;
    localparam int EN_MAPPER = 2;

    logic psg_hit;
    logic ppi_hit;
    logic mapper_hit;

    // Each device owns a block of four ports, so only bits 7:2 are compared
    assign psg_hit    = (io_addr[7:2] == PORT_PSG_BASE[7:2]);
    assign ppi_hit    = (io_addr[7:2] == PORT_PPI_BASE[7:2]);
    assign mapper_hit = (io_addr[7:2] == PORT_MAPPER_BASE[7:2]);

    // A disabled device never sees its ports
    assign psg_sel    = psg_hit && dev_enable[EN_PSG];
    assign ppi_sel    = ppi_hit && dev_enable[EN_PPI];
    assign mapper_sel = mapper_hit && dev_enable[EN_MAPPER];

    // Register index inside the device block
    assign reg_idx = io_addr[1:0];

    // Claim the data bus only for reads that land on an enabled device
    assign io_rdata_oe = io_rd && (psg_sel || ppi_sel || mapper_sel);

endmodule

//--- verilog/msx_io_pkg.sv
package msx_io_pkg;

    // I/O port map of the device block
    // Each base selects a group of four ports, the low two bits pick the register

    // PSG at A0..A2 (latch, write, read)
    localparam logic [7:0] PORT_PSG_BASE = 8'hA0;

    // PPI at A8..AB (slot, keyboard, port C, control)
    localparam logic [7:0] PORT_PPI_BASE = 8'hA8;

    // Memory mapper page registers at FC..FF
    localparam logic [7:0] PORT_MAPPER_BASE = 8'hFC;

    // Read byte of a device that is not addressed
    // The top level ANDs all device bytes together
    localparam logic [7:0] IO_IDLE = 8'hFF;

    // Audio scaling
    // One 4-bit volume step is worth 512 in the sum
    localparam int VOL_SCALE_SHIFT = 9;

    // Level added while the key beep bit is set
    localparam logic [15:0] KEYBEEP_LEVEL = 16'd12288;

    // Width of the signed mono sample
    localparam int SAMPLE_W = 16;

endpackage

//--- verilog/sound_mixer.sv
`timescale 1ns/1ps

module sound_mixer
    import msx_io_pkg::*;
(
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic [3:0]                 level_a,
    input  logic [3:0]                 level_b,
    input  logic [3:0]                 level_c,
    input  logic                       keybeep,
    output logic signed [SAMPLE_W-1:0] sound
);

    // One extra bit so the overflow past the signed maximum is visible
    localparam int SUM_W = SAMPLE_W + 1;
    localparam logic [SUM_W-1:0] SAMPLE_MAX = SUM_W'((1 << (SAMPLE_W - 1)) - 1);

    logic [5:0]       tone_sum;
    logic [SUM_W-1:0] mix;

    assign tone_sum = 6'(level_a) + 6'(level_b) + 6'(level_c);

    assign mix = (SUM_W'(tone_sum) << VOL_SCALE_SHIFT)
               + (keybeep ? SUM_W'(KEYBEEP_LEVEL) : '0);

    // All sources are positive, so only the top end needs clamping
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            sound <= '0;
        end else if (mix > SAMPLE_MAX) begin
            sound <= signed'(SAMPLE_MAX[SAMPLE_W-1:0]);
        end else begin
            sound <= signed'(mix[SAMPLE_W-1:0]);
        end
    end

endmodule
